// File: src/rvIsaPkg.sv
// RV32I instruction set encoding
// Opcodes, funct3 codes and field widths for the supported subset

package rvIsaPkg;

    parameter int xlen = 32;                   // Data and address width
    parameter int regAddrWidth = 5;            // Register index width

    typedef logic [xlen-1:0] word;
    typedef logic [regAddrWidth-1:0] regAddr;

    // Major opcodes, anything else is unsupported
    typedef enum logic [6:0] {
        opCompute   = 7'b0110011,              // R-type ALU
        opImmediate = 7'b0010011,              // I-type ALU
        opBranch    = 7'b1100011,
        opStore     = 7'b0100011,
        opJal       = 7'b1101111,
        opJalr      = 7'b1100111,
        opLui       = 7'b0110111,
        opAuipc     = 7'b0010111
    } opcode;

    // ALU funct3
    localparam logic [2:0] funcAddSub = 3'b000;
    localparam logic [2:0] funcSll    = 3'b001;
    localparam logic [2:0] funcSlt    = 3'b010;
    localparam logic [2:0] funcSltu   = 3'b011;
    localparam logic [2:0] funcXor    = 3'b100;
    localparam logic [2:0] funcSrlSra = 3'b101;
    localparam logic [2:0] funcOr     = 3'b110;
    localparam logic [2:0] funcAnd    = 3'b111;
    // Branch funct3
    localparam logic [2:0] funcBeq    = 3'b000;
    localparam logic [2:0] funcBne    = 3'b001;
    localparam logic [2:0] funcBlt    = 3'b100;
    localparam logic [2:0] funcBge    = 3'b101;
    localparam logic [2:0] funcBltu   = 3'b110;
    localparam logic [2:0] funcBgeu   = 3'b111;
    // Store funct3
    localparam logic [2:0] funcSb     = 3'b000;
    localparam logic [2:0] funcSh     = 3'b001;
    localparam logic [2:0] funcSw     = 3'b010;

    parameter int altBit = 30;                 // SUB and SRA select

endpackage

// File: src/corePkg.sv
// Core microarchitecture types
// Sequencer states, ALU operations, store sizes and the decoded instruction

package corePkg;

    typedef enum logic [2:0] {
        stFetch,                               // Instruction bus cycle
        stDecode,                              // Register read
        stExecute,                             // ALU, write-back, PC update
        stStore,                               // Data bus cycle
        stHalt                                 // Unsupported opcode seen
    } coreState;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd,
        aluPassB                               // LUI
    } aluOp;

    typedef enum logic [1:0] {
        sizeByte, sizeHalf, sizeWord
    } storeSize;

    typedef struct packed {
        rvIsaPkg::regAddr rd;
        rvIsaPkg::regAddr rs1;
        rvIsaPkg::regAddr rs2;
        rvIsaPkg::word    imm;                 // Sign-extended immediate
        aluOp             aluOp;
        storeSize         storeSize;
        logic             useImm;              // ALU B from immediate
        logic             writesRd;
        logic             isBranch;
        logic             isJal;
        logic             isJalr;
        logic             isStore;
        logic             isAuipc;
        logic             legal;
        logic [2:0]       branchFunct;
    } decodedInsn;

endpackage

// File: src/regPortIf.sv
// Register file access bundle
// Two combinational read ports and one clocked write port

`timescale 1ns/1ps

interface regPortIf;
    rvIsaPkg::regAddr rs1Addr;
    rvIsaPkg::regAddr rs2Addr;
    rvIsaPkg::word    rs1Data;
    rvIsaPkg::word    rs2Data;
    rvIsaPkg::regAddr wrAddr;
    rvIsaPkg::word    wrData;
    logic             wrEn;                    // Write on this clock edge

    modport core (output rs1Addr, rs2Addr, wrAddr, wrData, wrEn,
                  input  rs1Data, rs2Data);
    modport rf   (input  rs1Addr, rs2Addr, wrAddr, wrData, wrEn,
                  output rs1Data, rs2Data);
endinterface

// File: src/insnDecoder.sv
// Instruction decoder
// Field split, immediate build and classification of one RV32I word

`timescale 1ns/1ps

module insnDecoder (
    input  rvIsaPkg::word      insn,
    output corePkg::decodedInsn dec
);

    rvIsaPkg::opcode op;
    logic [2:0] funct3;
    rvIsaPkg::word immI, immS, immB, immU, immJ;

    // ALU op from funct3, subtract only when allowed
    function automatic corePkg::aluOp mapAlu(input logic [2:0] f3, input logic alt,
                                             input logic allowSub);
        case (f3)
            rvIsaPkg::funcAddSub: mapAlu = (alt && allowSub) ? corePkg::aluSub : corePkg::aluAdd;
            rvIsaPkg::funcSll:    mapAlu = corePkg::aluSll;
            rvIsaPkg::funcSlt:    mapAlu = corePkg::aluSlt;
            rvIsaPkg::funcSltu:   mapAlu = corePkg::aluSltu;
            rvIsaPkg::funcXor:    mapAlu = corePkg::aluXor;
            rvIsaPkg::funcSrlSra: mapAlu = alt ? corePkg::aluSra : corePkg::aluSrl;
            rvIsaPkg::funcOr:     mapAlu = corePkg::aluOr;
            default:              mapAlu = corePkg::aluAnd;
        endcase
    endfunction

    assign op     = rvIsaPkg::opcode'(insn[6:0]);
    assign funct3 = insn[14:12];

    assign immI = {{20{insn[31]}}, insn[31:20]};
    assign immS = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    assign immB = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    assign immU = {insn[31:12], 12'b0};
    assign immJ = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

    always_comb begin
        dec             = '0;
        dec.rd          = insn[11:7];
        dec.rs1         = insn[19:15];
        dec.rs2         = insn[24:20];
        dec.branchFunct = funct3;
        dec.legal       = 1'b1;
        case (op)
            rvIsaPkg::opCompute: begin
                dec.aluOp    = mapAlu(funct3, insn[rvIsaPkg::altBit], 1'b1);
                dec.writesRd = 1'b1;
            end
            rvIsaPkg::opImmediate: begin
                dec.imm      = immI;
                dec.useImm   = 1'b1;
                dec.aluOp    = mapAlu(funct3, immI[rvIsaPkg::altBit-20], 1'b0); // SRAI
                dec.writesRd = 1'b1;
            end
            rvIsaPkg::opBranch: begin
                dec.imm      = immB;
                dec.isBranch = 1'b1;
            end
            rvIsaPkg::opStore: begin
                dec.imm      = immS;
                dec.isStore  = 1'b1;
                case (funct3)
                    rvIsaPkg::funcSb: dec.storeSize = corePkg::sizeByte;
                    rvIsaPkg::funcSh: dec.storeSize = corePkg::sizeHalf;
                    rvIsaPkg::funcSw: dec.storeSize = corePkg::sizeWord;
                    default:          dec.legal     = 1'b0;   // No such store
                endcase
            end
            rvIsaPkg::opJal: begin
                dec.imm      = immJ;
                dec.isJal    = 1'b1;
                dec.writesRd = 1'b1;
            end
            rvIsaPkg::opJalr: begin
                dec.imm      = immI;
                dec.isJalr   = 1'b1;
                dec.writesRd = 1'b1;
            end
            rvIsaPkg::opLui: begin
                dec.imm      = immU;
                dec.useImm   = 1'b1;
                dec.aluOp    = corePkg::aluPassB;       // Immediate straight through
                dec.writesRd = 1'b1;
            end
            rvIsaPkg::opAuipc: begin
                dec.imm      = immU;
                dec.isAuipc  = 1'b1;
                dec.writesRd = 1'b1;
            end
            default: dec.legal = 1'b0;                  // Unsupported opcode
        endcase
    end

endmodule

// File: src/regFile.sv
// Integer register file
// 32 x 32 bits, two asynchronous reads, one synchronous write, x0 reads zero

`timescale 1ns/1ps

module regFile (
    input logic clk,
    regPortIf.rf port
);

    rvIsaPkg::word regs [0:31];

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (port.wrEn && (port.wrAddr != '0)) begin  // x0 never written
            regs[port.wrAddr] <= port.wrData;
        end
    end

    //////////////////////////////
    // Read ports
    //////////////////////////////
    assign port.rs1Data = (port.rs1Addr == '0) ? '0 : regs[port.rs1Addr];
    assign port.rs2Data = (port.rs2Addr == '0) ? '0 : regs[port.rs2Addr];

endmodule

// File: src/execUnit.sv
// Execute stage datapath
// ALU, branch compare, next PC, link value and store lane alignment

`timescale 1ns/1ps

module execUnit (
    input  rvIsaPkg::word       pc,
    input  rvIsaPkg::word       opA,
    input  rvIsaPkg::word       opB,
    input  corePkg::decodedInsn dec,
    output rvIsaPkg::word       result,
    output rvIsaPkg::word       nextPc,
    output rvIsaPkg::word       storeAdr,
    output rvIsaPkg::word       storeDat,
    output logic [3:0]          storeSel
);

    rvIsaPkg::word aluB, aluOut, pcPlus4, pcTarget, jalrTarget, storeSum;
    logic [4:0] shamt;
    logic taken;

    assign aluB  = dec.useImm ? dec.imm : opB;     // Register or immediate
    assign shamt = aluB[4:0];

    //////////////////////////////
    // ALU
    //////////////////////////////
    always_comb begin
        case (dec.aluOp)
            corePkg::aluAdd:  aluOut = opA + aluB;
            corePkg::aluSub:  aluOut = opA - aluB;
            corePkg::aluSll:  aluOut = opA << shamt;
            corePkg::aluSlt:  aluOut = {31'b0, $signed(opA) < $signed(aluB)};
            corePkg::aluSltu: aluOut = {31'b0, opA < aluB};
            corePkg::aluXor:  aluOut = opA ^ aluB;
            corePkg::aluSrl:  aluOut = opA >> shamt;
            corePkg::aluSra:  aluOut = $signed(opA) >>> shamt;
            corePkg::aluOr:   aluOut = opA | aluB;
            corePkg::aluAnd:  aluOut = opA & aluB;
            default:          aluOut = aluB;        // Pass B for LUI
        endcase
    end

    assign pcPlus4    = pc + 32'd4;
    assign pcTarget   = pc + dec.imm;               // Branch, JAL, AUIPC
    assign jalrTarget = (opA + dec.imm) & ~32'd1;

    assign result = (dec.isJal || dec.isJalr) ? pcPlus4  // Link value
                  : dec.isAuipc               ? pcTarget
                  :                             aluOut;

    //////////////////////////////
    // Branch and next PC
    //////////////////////////////
    always_comb begin
        case (dec.branchFunct)
            rvIsaPkg::funcBeq:  taken = (opA == opB);
            rvIsaPkg::funcBne:  taken = (opA != opB);
            rvIsaPkg::funcBlt:  taken = ($signed(opA) < $signed(opB));
            rvIsaPkg::funcBge:  taken = ($signed(opA) >= $signed(opB));
            rvIsaPkg::funcBltu: taken = (opA < opB);
            rvIsaPkg::funcBgeu: taken = (opA >= opB);
            default:            taken = 1'b0;
        endcase
    end

    assign nextPc = dec.isJalr                          ? jalrTarget
                  : ((dec.isBranch && taken) || dec.isJal) ? pcTarget
                  :                                       pcPlus4;

    //////////////////////////////
    // Store alignment
    //////////////////////////////
    assign storeSum = opA + dec.imm;
    assign storeAdr = {storeSum[31:2], 2'b00};      // Word address on the bus

    always_comb begin
        case (dec.storeSize)
            corePkg::sizeByte: begin
                storeSel = 4'b0001 << storeSum[1:0];
                storeDat = {4{opB[7:0]}};           // Byte on every lane
            end
            corePkg::sizeHalf: begin
                storeSel = storeSum[1] ? 4'b1100 : 4'b0011;
                storeDat = {2{opB[15:0]}};
            end
            default: begin
                storeSel = 4'b1111;
                storeDat = opB;
            end
        endcase
    end

endmodule

// File: src/coreControl.sv
// Core sequencer
// Fetch, decode, execute and store states, PC and instruction register,
// and the Wishbone classic masters for instructions and stores

`timescale 1ns/1ps

module coreControl #(
    parameter rvIsaPkg::word resetVector = 32'h0
) (
    input  logic                clk,
    input  logic                rst,
    output rvIsaPkg::word       insnAdr,
    input  rvIsaPkg::word       insnDatIn,
    output logic                insnCyc,
    output logic                insnStb,
    input  logic                insnAck,
    output rvIsaPkg::word       dataAdr,
    output rvIsaPkg::word       dataDatOut,
    output logic [3:0]          dataSel,
    output logic                dataWe,
    output logic                dataCyc,
    output logic                dataStb,
    input  logic                dataAck,
    output logic                halt,
    input  corePkg::decodedInsn dec,
    output rvIsaPkg::word       insnWord,
    regPortIf.core              rf,
    output rvIsaPkg::word       pc,
    output rvIsaPkg::word       opA,
    output rvIsaPkg::word       opB,
    input  rvIsaPkg::word       result,
    input  rvIsaPkg::word       nextPc,
    input  rvIsaPkg::word       storeAdr,
    input  rvIsaPkg::word       storeDat,
    input  logic [3:0]          storeSel
);

    corePkg::coreState state;
    rvIsaPkg::word insnReg;                         // Instruction register

    assign insnAdr  = pc;                           // Held for the whole fetch
    assign insnStb  = insnCyc;                      // Classic cycle, stb with cyc
    assign dataStb  = dataCyc;
    assign dataWe   = 1'b1;                         // Store-only port
    assign insnWord = insnReg;

    // Register file access straight from the decoded word
    assign rf.rs1Addr = dec.rs1;
    assign rf.rs2Addr = dec.rs2;
    assign rf.wrAddr  = dec.rd;
    assign rf.wrData  = result;
    assign rf.wrEn    = (state == corePkg::stExecute) && dec.writesRd;

    //////////////////////////////
    // Sequencer
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= corePkg::stFetch;
            pc      <= resetVector;
            insnCyc <= 1'b0;
            dataCyc <= 1'b0;
            halt    <= 1'b0;
        end else begin
            case (state)
                corePkg::stFetch: begin
                    if (!insnCyc) begin
                        insnCyc <= 1'b1;            // First fetch after reset
                    end else if (insnAck) begin
                        insnCyc <= 1'b0;
                        state   <= corePkg::stDecode;
                    end
                end
                corePkg::stDecode: begin
                    if (!dec.legal) begin
                        halt  <= 1'b1;              // Sticky until reset
                        state <= corePkg::stHalt;
                    end else begin
                        state <= corePkg::stExecute;
                    end
                end
                corePkg::stExecute: begin
                    pc <= nextPc;
                    if (dec.isStore) begin
                        dataCyc <= 1'b1;
                        state   <= corePkg::stStore;
                    end else begin
                        insnCyc <= 1'b1;            // Next fetch right away
                        state   <= corePkg::stFetch;
                    end
                end
                corePkg::stStore: begin
                    if (dataAck) begin
                        dataCyc <= 1'b0;
                        insnCyc <= 1'b1;
                        state   <= corePkg::stFetch;
                    end
                end
                default: state <= corePkg::stHalt;  // No more bus cycles
            endcase
        end
    end

    //////////////////////////////
    // Payload registers
    //////////////////////////////
    always_ff @(posedge clk) begin
        if ((state == corePkg::stFetch) && insnCyc && insnAck) begin
            insnReg <= insnDatIn;
        end
        if (state == corePkg::stDecode) begin
            opA <= rf.rs1Data;                      // Registered operands
            opB <= rf.rs2Data;
        end
        if ((state == corePkg::stExecute) && dec.isStore) begin
            dataAdr    <= storeAdr;
            dataDatOut <= storeDat;
            dataSel    <= storeSel;
        end
    end

endmodule

// File: src/rvCore.sv
// RV32I multi-cycle core top level
// Instruction fetch and store-only data Wishbone classic masters, halt on
// unsupported opcode

`timescale 1ns/1ps

module rvCore #(
    parameter rvIsaPkg::word resetVector = 32'h0
) (
    input  logic          clk,
    input  logic          rst,
    output rvIsaPkg::word insnAdr,
    input  rvIsaPkg::word insnDatIn,
    output logic          insnCyc,
    output logic          insnStb,
    input  logic          insnAck,
    output rvIsaPkg::word dataAdr,
    output rvIsaPkg::word dataDatOut,
    output logic [3:0]    dataSel,
    output logic          dataWe,
    output logic          dataCyc,
    output logic          dataStb,
    input  logic          dataAck,
    output logic          halt
);

    corePkg::decodedInsn dec;
    rvIsaPkg::word insnWord, pc, opA, opB;
    rvIsaPkg::word result, nextPc, storeAdr, storeDat;
    logic [3:0] storeSel;

    regPortIf regPort ();

    insnDecoder decoder (.insn(insnWord), .dec(dec));

    regFile registers (.clk(clk), .port(regPort.rf));

    execUnit execute (
        .pc(pc), .opA(opA), .opB(opB), .dec(dec),
        .result(result), .nextPc(nextPc),
        .storeAdr(storeAdr), .storeDat(storeDat), .storeSel(storeSel)
    );

    coreControl #(.resetVector(resetVector)) control (
        .clk(clk), .rst(rst),
        .insnAdr(insnAdr), .insnDatIn(insnDatIn), .insnCyc(insnCyc),
        .insnStb(insnStb), .insnAck(insnAck),
        .dataAdr(dataAdr), .dataDatOut(dataDatOut), .dataSel(dataSel),
        .dataWe(dataWe), .dataCyc(dataCyc), .dataStb(dataStb), .dataAck(dataAck),
        .halt(halt), .dec(dec), .insnWord(insnWord), .rf(regPort.core),
        .pc(pc), .opA(opA), .opB(opB),
        .result(result), .nextPc(nextPc),
        .storeAdr(storeAdr), .storeDat(storeDat), .storeSel(storeSel)
    );

endmodule

// File: tests/coreModel.svh
// Program generator and instruction-set reference model for the core testbench
// Builds a forward-only random RV32I program and predicts fetches and stores

`ifndef COREMODEL_SVH
`define COREMODEL_SVH

logic [31:0] imem [0:63];                       // Instruction memory, word indexed
logic [31:0] expFetch [$];                      // Expected fetch addresses in order
logic [31:0] expStAdr [$];
logic [31:0] expStDat [$];
logic [3:0]  expStSel [$];

// Fills imem with forward-only control flow and a zero word last
task automatic buildProgram();
    logic [31:0] r, r2;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3, sf3;
    logic [11:0] imm, off;
    int sel;
    int brCount;
    brCount = 0;
    for (int i = 0; i < 63; i++) begin
        r   = $random(seed);
        r2  = $random(seed);                    // Immediates and upper bits
        rd  = (r[2:0] == 3'd0) ? 5'd1 : {2'b0, r[2:0]};
        rs1 = {2'b0, r[5:3]};                   // x0 to x7
        rs2 = {2'b0, r[8:6]};
        f3  = r[11:9];
        sel = r[31:24] % 10;
        if (i == 39 || i > 60) sel = sel % 5;   // No jump over the JALR or off the end
        if (i < 7) begin
            imem[i] = i[0] ? {r2[31:12], 5'(i + 1), 7'h37}          // LUI seed
                           : {r2[11:0], 5'd0, 3'd0, 5'(i + 1), 7'h13}; // ADDI seed
        end else if (i == 40) begin
            imem[i] = {12'(resetVec + i * 4 + 8), 5'd0, 3'd0, rd, 7'h67}; // JALR to i+2
        end else if (sel < 3) begin
            imem[i] = {((f3 == 3'd0 || f3 == 3'd5) && r[12]) ? 7'h20 : 7'h00,
                       rs2, rs1, f3, rd, 7'h33};
        end else if (sel < 5) begin
            imm = (f3 == 3'd1) ? {7'd0, r2[4:0]}                    // SLLI
                : (f3 == 3'd5) ? {1'b0, r[12], 5'd0, r2[4:0]}       // SRLI or SRAI
                : r2[11:0];
            imem[i] = {imm, rs1, f3, rd, 7'h13};
        end else if (sel < 7) begin
            f3 = (brCount % 6 < 2) ? 3'(brCount % 6) : 3'(brCount % 6 + 2); // All six kinds
            brCount++;
            imem[i] = {7'd0, rs2, rs1, f3, 4'b0100, 1'b0, 7'h63};   // Offset 8
        end else if (sel == 7) begin
            imem[i] = {1'b0, 10'd4, 1'b0, 8'd0, rd, 7'h6f};        // JAL offset 8
        end else if (sel == 8) begin
            sf3 = (r[13:12] == 2'd3) ? 3'd2 : {1'b0, r[13:12]};
            off = {1'b0, r2[10:0]} & ~((12'd1 << sf3) - 12'd1);     // Aligned offset below 2048
            imem[i] = {off[11:5], rs2, 5'd0, sf3, off[4:0], 7'h23};
        end else begin
            imem[i] = {r2[31:12], rd, r[12] ? 7'h17 : 7'h37};       // AUIPC or LUI
        end
    end
    imem[63] = 32'd0;                           // Unsupported opcode ends the run
endtask

function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                     input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        default: return a >= b;
    endcase
endfunction

// Runs imem from the reset vector and records the fetch trace and store list
task automatic runModel();
    logic [31:0] x [0:31];
    logic [31:0] pc, w, a, b, immI, res, sum, nextPc;
    logic wr;
    for (int k = 0; k < 32; k++) x[k] = 32'd0;
    pc = resetVec;
    repeat (200) begin
        w = imem[pc[7:2]];
        expFetch.push_back(pc);
        a = x[w[19:15]];
        b = x[w[24:20]];
        immI = {{20{w[31]}}, w[31:20]};
        nextPc = pc + 32'd4;
        wr = 1'b1;
        case (w[6:0])
            7'h33: res = aluModel(w[14:12], w[30], a, b);
            7'h13: res = aluModel(w[14:12], w[30] && (w[14:12] == 3'd5), a, immI);
            7'h37: res = {w[31:12], 12'd0};
            7'h17: res = pc + {w[31:12], 12'd0};
            7'h6f: begin
                res = pc + 32'd4;                // Link
                nextPc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            7'h67: begin
                res = pc + 32'd4;
                nextPc = (a + immI) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                if (branchTaken(w[14:12], a, b))
                    nextPc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            7'h23: begin
                wr = 1'b0;
                sum = a + {{20{w[31]}}, w[31:25], w[11:7]};
                expStAdr.push_back({sum[31:2], 2'b00});
                case (w[14:12])
                    3'd0: begin
                        expStSel.push_back(4'b0001 << sum[1:0]);
                        expStDat.push_back({4{b[7:0]}});
                    end
                    3'd1: begin
                        expStSel.push_back(sum[1] ? 4'b1100 : 4'b0011);
                        expStDat.push_back({2{b[15:0]}});
                    end
                    default: begin
                        expStSel.push_back(4'b1111);
                        expStDat.push_back(b);
                    end
                endcase
            end
            default: return;                    // Core halts here
        endcase
        if (wr && w[11:7] != 5'd0) x[w[11:7]] = res;
        pc = nextPc;
    end
endtask

`endif

// File: tests/coreTb.sv
// Testbench for the RV32I multi-cycle core
// Random program, Wishbone responders with random wait states, fetch and
// store streams checked against the reference model

`timescale 1ns/1ps

module coreTb;

    localparam logic [31:0] resetVec = 32'h0000_0100;

    logic clk, rst;
    logic [31:0] insnAdr, insnDatIn, dataAdr, dataDatOut;
    logic insnCyc, insnStb, insnAck;
    logic dataWe, dataCyc, dataStb, dataAck, halt;
    logic [3:0] dataSel;

    integer seed = 32'h095097a0;
    int errors = 0;
    int checks = 0;
    int fetchCount = 0;                         // Fetches seen on the bus
    int storeCount = 0;
    int insnWait, dataWait;
    logic insnBusy, dataBusy;                   // Request in progress
    logic [31:0] insnHeld;
    logic [67:0] storeHeld;                     // Held address, select and data

    `include "coreModel.svh"

    rvCore #(.resetVector(resetVec)) rvCore_inst (.*);

    task automatic checkValue(input string name, input logic [71:0] expected,
                              input logic [71:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                 // 40 ns period
    end

    //////////////////////////////
    // Instruction bus responder
    //////////////////////////////
    always @(negedge clk) begin
        if (insnAck) begin
            insnAck = 1'b0;                     // Ack lasts one cycle
        end else if (insnCyc && insnStb) begin
            if (!insnBusy) begin
                insnBusy = 1'b1;
                insnHeld = insnAdr;
                insnWait = $random(seed) & 3;
                if (fetchCount < expFetch.size()) begin
                    checkValue("fetch address", expFetch[fetchCount], insnAdr);
                end else begin
                    errors++;
                    $display("Fetch past the end of the expected program trace");
                end
                fetchCount++;
            end
            checkValue("fetch address hold", insnHeld, insnAdr);
            if (insnWait == 0) begin
                insnAck   = 1'b1;
                insnDatIn = imem[insnAdr[7:2]];
                insnBusy  = 1'b0;
            end else begin
                insnWait--;
            end
        end
    end

    //////////////////////////////
    // Data bus responder
    //////////////////////////////
    always @(negedge clk) begin
        if (dataAck) begin
            dataAck = 1'b0;
        end else if (dataCyc && dataStb) begin
            if (!dataBusy) begin
                dataBusy  = 1'b1;
                storeHeld = {dataAdr, dataSel, dataDatOut};
                dataWait  = $random(seed) & 3;
                if (storeCount < expStAdr.size()) begin
                    checkValue("store address", expStAdr[storeCount], dataAdr);
                    checkValue("store select", expStSel[storeCount], dataSel);
                    checkValue("store data", expStDat[storeCount], dataDatOut);
                end else begin
                    errors++;
                    $display("More stores on the data bus than the program makes");
                end
                storeCount++;
            end
            checkValue("store write enable", 1'b1, dataWe);
            checkValue("store hold", storeHeld, {dataAdr, dataSel, dataDatOut});
            if (dataWait == 0) begin
                dataAck  = 1'b1;
                dataBusy = 1'b0;
            end else begin
                dataWait--;
            end
        end
    end

    //////////////////////////////
    // Sequence
    //////////////////////////////
    initial begin
        int timer;
        rst       = 1'b1;
        insnAck   = 1'b0;
        insnDatIn = 32'd0;
        dataAck   = 1'b0;
        insnBusy  = 1'b0;
        dataBusy  = 1'b0;
        buildProgram();
        runModel();
        repeat (10) begin
            @(negedge clk);
            checkValue("bus idle in reset", 5'd0, {insnCyc, insnStb, dataCyc, dataStb, halt});
        end
        rst = 1'b0;
        timer = 0;
        while (!insnCyc && timer < 10) begin    // First fetch
            @(negedge clk);
            timer++;
        end
        if (!insnCyc) begin
            errors++;
            $display("Timeout: first instruction fetch never started");
        end
        checkValue("first fetch cycle", 1, timer);  // One clock after reset release
        checkValue("data bus idle after reset", 3'd0, {dataCyc, dataStb, halt});
        checkValue("first fetch address", resetVec, insnAdr);
        timer = 0;
        while (!halt && timer < 5000) begin
            @(negedge clk);
            timer++;
        end
        if (!halt) begin
            errors++;
            $display("Timeout: core never raised halt");
        end
        repeat (20) begin                       // Halt stays high with the buses idle
            @(negedge clk);
            checkValue("halted bus idle", 5'b00001, {insnCyc, insnStb, dataCyc, dataStb, halt});
        end
        checkValue("fetch count", expFetch.size(), fetchCount);
        checkValue("store count", expStAdr.size(), storeCount);
        $display("%0d checks, %0d errors, %0d fetches, %0d stores",
                 checks, errors, fetchCount, storeCount);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
+incdir+tests
src/rvIsaPkg.sv
src/corePkg.sv
src/regPortIf.sv
src/insnDecoder.sv
src/regFile.sv
src/execUnit.sv
src/coreControl.sv
src/rvCore.sv
tests/coreTb.sv
